// File: src/fb_tx_pkg.sv
/* fieldbus h1 transmit definitions */

package fb_tx_pkg;

    // ****************************************
    // frame phases and line symbols
    // ****************************************

    // phase order on the line, idle between frames
    typedef enum logic [2:0]
    {
        IDLE     = 3'd0,
        PREAMBLE = 3'd1,
        SD       = 3'd2,
        DATA     = 3'd3,
        FCS      = 3'd4,
        ED       = 3'd5
    } tx_phase_t;

    // manchester symbols, two half-bit levels each
    typedef enum logic [1:0]
    {
        ZERO   = 2'b00,
        ONE    = 2'b01,
        NPLUS  = 2'b10,
        NMINUS = 2'b11
    } tx_sym_t;

    // ****************************************
    // bundles
    // ****************************************

    // one octet from the host, last marks the end of the frame
    typedef struct packed
    {
        logic [7:0] data;
        logic       last;
    } tx_octet_t;

    // timing broadcast from the serializer
    typedef struct packed
    {
        tx_phase_t  phase;
        logic [3:0] cnt;
        logic       sym_start;
        logic       sym_end;
    } tx_ctrl_t;

    // ****************************************
    // delimiters and fcs
    // ****************************************

    // first symbol sits in the top two bits
    localparam logic [15:0] SD_PATTERN = {ONE, NPLUS, NMINUS, ONE, ZERO, NMINUS, NPLUS, ZERO};
    localparam logic [15:0] ED_PATTERN = {ONE, NPLUS, NMINUS, NPLUS, NMINUS, ONE, ZERO, ONE};

    // crc register start value
    localparam logic [15:0] FCS_INIT = 16'hffff;

endpackage

// File: src/tx_serializer.sv
/* transmit serializer and frame sequencer */

module tx_serializer
(
    input  logic                 clk16x,
    input  logic                 arst_n,
    input  logic                 req,
    input  fb_tx_pkg::tx_octet_t oct,
    output logic                 ack,
    output fb_tx_pkg::tx_ctrl_t  ctrl,
    input  logic                 pre_done,
    input  logic                 ed_done,
    output logic                 fcs_init,
    output logic                 data_bit,
    output logic                 data_fcs_n,
    output logic                 underrun,
    output logic                 busy
);
    import fb_tx_pkg::*;

    tx_phase_t  phase_q;
    logic [3:0] cnt_q;
    logic [3:0] sym_idx_q;
    logic       buf_valid_q;
    logic       last_seen_q;
    tx_octet_t  buf_q;
    logic [7:0] sh_q;
    logic       sh_last_q;
    logic       start;
    logic       load;
    logic       sym_end;
    logic       octet_end;
    logic       xfer;

    // ****************************************
    // host handshake and buffer
    // ****************************************

    // new frame only from idle with the previous ack gone
    assign start = (phase_q == IDLE) && req && !ack;

    // no loads once the last octet of the frame is in
    assign load = req && !ack && !buf_valid_q &&
                  ((phase_q == IDLE) ||
                   (!last_seen_q && (phase_q inside {PREAMBLE, SD, DATA})));

    // symbol timing
    assign sym_end   = (phase_q != IDLE) && (cnt_q == 4'd15);
    assign octet_end = sym_end && (sym_idx_q[2:0] == 3'd7);

    // buffer moves to the shifter at the first bit of each data octet
    assign xfer = octet_end &&
                  ((phase_q == SD) || ((phase_q == DATA) && !sh_last_q && buf_valid_q));

    // payload path
    always_ff @(posedge clk16x)
    begin
        if (load)
        begin
            buf_q <= oct;
        end
        if (xfer)
        begin
            sh_q      <= buf_q.data;
            sh_last_q <= buf_q.last;
        end
        else if ((phase_q == DATA) && sym_end)
        begin
            // msb first
            sh_q <= {sh_q[6:0], 1'b0};
        end
    end

    // ****************************************
    // phase fsm and counters
    // ****************************************

    always_ff @(posedge clk16x or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase_q     <= IDLE;
            cnt_q       <= 4'd0;
            sym_idx_q   <= 4'd0;
            ack         <= 1'b0;
            buf_valid_q <= 1'b0;
            last_seen_q <= 1'b0;
            underrun    <= 1'b0;
        end
        else
        begin
            // four-phase ack
            if (load)
            begin
                ack <= 1'b1;
            end
            else if (!req)
            begin
                ack <= 1'b0;
            end

            if (xfer)
            begin
                buf_valid_q <= 1'b0;
            end
            else if (load)
            begin
                buf_valid_q <= 1'b1;
            end

            if (load)
            begin
                last_seen_q <= oct.last;
            end

            // wraps to 0 at each symbol boundary
            if (phase_q != IDLE)
            begin
                cnt_q <= cnt_q + 4'd1;
            end

            if (sym_end)
            begin
                sym_idx_q <= sym_idx_q + 4'd1;
            end

            case (phase_q)
                IDLE:
                begin
                    if (start)
                    begin
                        phase_q  <= PREAMBLE;
                        cnt_q    <= 4'd0;
                        underrun <= 1'b0;
                    end
                end
                PREAMBLE:
                begin
                    if (pre_done)
                    begin
                        phase_q   <= SD;
                        sym_idx_q <= 4'd0;
                    end
                end
                SD:
                begin
                    if (octet_end)
                    begin
                        phase_q <= DATA;
                    end
                end
                DATA:
                begin
                    if (octet_end && sh_last_q)
                    begin
                        phase_q   <= FCS;
                        sym_idx_q <= 4'd0;
                    end
                    else if (octet_end && !buf_valid_q)
                    begin
                        // host too slow, drop the frame
                        phase_q  <= IDLE;
                        underrun <= 1'b1;
                    end
                end
                FCS:
                begin
                    if (sym_end && (sym_idx_q == 4'd15))
                    begin
                        phase_q <= ED;
                    end
                end
                ED:
                begin
                    if (ed_done)
                    begin
                        phase_q <= IDLE;
                    end
                end
                default:
                begin
                    phase_q <= IDLE;
                end
            endcase
        end
    end

    // ****************************************
    // outputs
    // ****************************************

    assign ctrl.phase     = phase_q;
    assign ctrl.cnt       = cnt_q;
    assign ctrl.sym_start = (phase_q != IDLE) && (cnt_q == 4'd0);
    assign ctrl.sym_end   = sym_end;

    assign fcs_init   = start;
    assign data_bit   = sh_q[7];
    assign data_fcs_n = (phase_q == DATA);
    assign busy       = (phase_q != IDLE);

endmodule

// File: src/tfcs.sv
/* serial fcs generator */

module tfcs
(
    input  logic                clk16x,
    input  logic                arst_n,
    input  logic                fcs_init,
    input  fb_tx_pkg::tx_ctrl_t ctrl,
    input  logic                data_fcs_n,
    input  logic                data_bit,
    output logic                line_bit
);
    import fb_tx_pkg::*;

    // x^16 + x^12 + x^11 + x^10 + x^8 + x^7 + x^6 + x^3 + x^2 + x + 1
    localparam logic [15:0] FCS_POLY = 16'h1dcf;

    logic [15:0] d_q;
    logic        feed_back;
    logic        step;

    // zero feedback while sending, the register just shifts out
    assign feed_back = data_fcs_n ? (data_bit ^ d_q[15]) : 1'b0;

    // one step per bit, at the end of its symbol
    assign step = ctrl.sym_end && ((ctrl.phase == DATA) || (ctrl.phase == FCS));

    // ****************************************
    // crc register
    // ****************************************

    always_ff @(posedge clk16x or negedge arst_n)
    begin
        if (!arst_n)
        begin
            d_q <= FCS_INIT;
        end
        else if (fcs_init)
        begin
            // fresh crc per frame
            d_q <= FCS_INIT;
        end
        else if (step)
        begin
            d_q <= {d_q[14:0], 1'b0} ^ (feed_back ? FCS_POLY : 16'h0000);
        end
    end

    // ****************************************
    // bit to line
    // ****************************************

    // data passes straight, fcs goes out inverted msb first
    assign line_bit = data_fcs_n ? data_bit : ~d_q[15];

endmodule

// File: src/tx_delimiter_gen.sv
/* preamble and delimiter sequencer */

module tx_delimiter_gen
#(
    parameter int PREAMBLE_OCTETS = 1
)
(
    input  logic                clk16x,
    input  logic                arst_n,
    input  fb_tx_pkg::tx_ctrl_t ctrl,
    output fb_tx_pkg::tx_sym_t  delim_sym,
    output logic                pre_done,
    output logic                ed_done
);
    import fb_tx_pkg::*;

    // index of the final preamble octet
    localparam logic [2:0] PRE_LAST = 3'(PREAMBLE_OCTETS - 1);

    logic [2:0] idx_q;
    logic [2:0] oct_q;
    logic       delim_phase;

    // pick symbol i out of an 8-symbol pattern, first symbol at the top
    function automatic tx_sym_t pattern_sym(input logic [15:0] pat, input logic [2:0] i);
        logic [15:0] shifted;
        shifted = pat << {i, 1'b0};
        return tx_sym_t'(shifted[15:14]);
    endfunction

    assign delim_phase = ctrl.phase inside {PREAMBLE, SD, ED};

    // ****************************************
    // symbol and octet counters
    // ****************************************

    always_ff @(posedge clk16x or negedge arst_n)
    begin
        if (!arst_n)
        begin
            idx_q <= 3'd0;
            oct_q <= 3'd0;
        end
        else if (!delim_phase)
        begin
            idx_q <= 3'd0;
            oct_q <= 3'd0;
        end
        else if (ctrl.sym_end)
        begin
            // wraps to 0 when a part of 8 symbols is done
            idx_q <= idx_q + 3'd1;
            if ((ctrl.phase == PREAMBLE) && (idx_q == 3'd7))
            begin
                oct_q <= (oct_q == PRE_LAST) ? 3'd0 : oct_q + 3'd1;
            end
        end
    end

    // done strobes land on the final symbol-end of each part
    assign pre_done = (ctrl.phase == PREAMBLE) && ctrl.sym_end &&
                      (idx_q == 3'd7) && (oct_q == PRE_LAST);
    assign ed_done  = (ctrl.phase == ED) && ctrl.sym_end && (idx_q == 3'd7);

    // ****************************************
    // symbol select
    // ****************************************

    always_comb
    begin
        case (ctrl.phase)
            // 10101010 per preamble octet
            PREAMBLE: delim_sym = idx_q[0] ? ZERO : ONE;
            SD:       delim_sym = pattern_sym(SD_PATTERN, idx_q);
            ED:       delim_sym = pattern_sym(ED_PATTERN, idx_q);
            default:  delim_sym = ONE;
        endcase
    end

endmodule

// File: src/tx_manchester.sv
/* manchester line combiner */

module tx_manchester
(
    input  logic                clk16x,
    input  logic                arst_n,
    input  fb_tx_pkg::tx_ctrl_t ctrl,
    input  fb_tx_pkg::tx_sym_t  delim_sym,
    input  logic                line_bit,
    output logic                txd,
    output logic                tx_en
);
    import fb_tx_pkg::*;

    tx_sym_t sym_sel;
    tx_sym_t sym_q;
    tx_sym_t sym_now;
    logic    level;

    // ****************************************
    // symbol source
    // ****************************************

    // data and fcs bits come from tfcs, the rest from the delimiter block
    always_comb
    begin
        if ((ctrl.phase == DATA) || (ctrl.phase == FCS))
        begin
            sym_sel = line_bit ? ONE : ZERO;
        end
        else
        begin
            sym_sel = delim_sym;
        end
    end

    // symbol is held for its full 16 cycles
    always_ff @(posedge clk16x or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sym_q <= ONE;
        end
        else if (ctrl.sym_start)
        begin
            sym_q <= sym_sel;
        end
    end

    assign sym_now = ctrl.sym_start ? sym_sel : sym_q;

    // ****************************************
    // half-bit levels
    // ****************************************

    // cnt[3] low in the first half, high in the second
    always_comb
    begin
        case (sym_now)
            ONE:     level = ~ctrl.cnt[3];
            ZERO:    level = ctrl.cnt[3];
            NPLUS:   level = 1'b1;
            default: level = 1'b0;
        endcase
    end

    // output register, idle line sits high with enable off
    always_ff @(posedge clk16x or negedge arst_n)
    begin
        if (!arst_n)
        begin
            txd   <= 1'b1;
            tx_en <= 1'b0;
        end
        else if (ctrl.phase == IDLE)
        begin
            txd   <= 1'b1;
            tx_en <= 1'b0;
        end
        else
        begin
            txd   <= level;
            tx_en <= 1'b1;
        end
    end

endmodule

// File: src/fb_tx_top.sv
/* fieldbus h1 transmit top */

module fb_tx_top
#(
    parameter int PREAMBLE_OCTETS = 1
)
(
    input  logic                 clk16x,
    input  logic                 arst_n,
    input  logic                 req,
    input  fb_tx_pkg::tx_octet_t oct,
    output logic                 ack,
    output logic                 txd,
    output logic                 tx_en,
    output logic                 underrun,
    output logic                 busy
);
    import fb_tx_pkg::*;

    // timing broadcast
    tx_ctrl_t ctrl;

    // serializer to fcs path
    logic fcs_init;
    logic data_bit;
    logic data_fcs_n;
    logic line_bit;

    // delimiter path
    tx_sym_t delim_sym;
    logic    pre_done;
    logic    ed_done;

    // ****************************************
    // sequencing
    // ****************************************

    tx_serializer u_serializer
    (
        .clk16x     (clk16x),
        .arst_n     (arst_n),
        .req        (req),
        .oct        (oct),
        .ack        (ack),
        .ctrl       (ctrl),
        .pre_done   (pre_done),
        .ed_done    (ed_done),
        .fcs_init   (fcs_init),
        .data_bit   (data_bit),
        .data_fcs_n (data_fcs_n),
        .underrun   (underrun),
        .busy       (busy)
    );

    // ****************************************
    // symbol paths and line
    // ****************************************

    // data and fcs bits
    tfcs u_tfcs
    (
        .clk16x     (clk16x),
        .arst_n     (arst_n),
        .fcs_init   (fcs_init),
        .ctrl       (ctrl),
        .data_fcs_n (data_fcs_n),
        .data_bit   (data_bit),
        .line_bit   (line_bit)
    );

    tx_delimiter_gen #(.PREAMBLE_OCTETS(PREAMBLE_OCTETS)) u_delim
    (
        .clk16x    (clk16x),
        .arst_n    (arst_n),
        .ctrl      (ctrl),
        .delim_sym (delim_sym),
        .pre_done  (pre_done),
        .ed_done   (ed_done)
    );

    // one register stage to the line
    tx_manchester u_manchester
    (
        .clk16x    (clk16x),
        .arst_n    (arst_n),
        .ctrl      (ctrl),
        .delim_sym (delim_sym),
        .line_bit  (line_bit),
        .txd       (txd),
        .tx_en     (tx_en)
    );

endmodule

// File: dv/fb_tx_assertions.sv
/* handshake and line checks */

module fb_tx_assertions
(
    input logic                 clk16x,
    input logic                 arst_n,
    input logic                 req,
    input fb_tx_pkg::tx_octet_t oct,
    input logic                 ack,
    input logic                 txd,
    input logic                 tx_en
);
    timeunit 1ns;
    timeprecision 100ps;

    // ****************************************
    // host handshake
    // ****************************************

    // ack stays up as long as the host still requests
    ack_held: assert property (@(posedge clk16x) disable iff (!arst_n)
        (req && ack) |=> ack)
        else $error("ack dropped while req was still high");

    // octet must not move under a pending request
    oct_stable: assert property (@(posedge clk16x) disable iff (!arst_n)
        req |=> (!req || $stable(oct)))
        else $error("oct changed while req was high");

    // ****************************************
    // line
    // ****************************************

    // idle line sits high
    idle_high: assert property (@(posedge clk16x) disable iff (!arst_n)
        !tx_en |-> txd)
        else $error("txd low while tx_en is off");

endmodule

bind fb_tx_top fb_tx_assertions u_assertions
(
    .clk16x (clk16x),
    .arst_n (arst_n),
    .req    (req),
    .oct    (oct),
    .ack    (ack),
    .txd    (txd),
    .tx_en  (tx_en)
);

// File: dv/tb_fb_tx.sv
/* fieldbus h1 transmit testbench */

module tb_fb_tx;
    timeunit 1ns;
    timeprecision 100ps;

    import fb_tx_pkg::*;

    // two preamble octets so the octet counter wraps
    localparam int PREAMBLE_OCTETS = 2;
    localparam int NUM_RANDOM      = 6;

    // symbols in a full frame of n octets
    function automatic int frame_symbols(input int n);
        return 8 * PREAMBLE_OCTETS + 8 + 8 * n + 16 + 8;
    endfunction

    function automatic int frame_cycles(input int n);
        return 16 * frame_symbols(n);
    endfunction

    // random frames counted at their longest
    localparam int TIMEOUT_CYCLES = 2 * (frame_cycles(1) + NUM_RANDOM * frame_cycles(8) +
        frame_cycles(3) + frame_cycles(2) + frame_cycles(3)) + 2000;

    // delimiters in line order with the first symbol on top
    localparam logic [15:0] SD_SEQ = {ONE, NPLUS, NMINUS, ONE, ZERO, NMINUS, NPLUS, ZERO};
    localparam logic [15:0] ED_SEQ = {ONE, NPLUS, NMINUS, NPLUS, NMINUS, ONE, ZERO, ONE};

    logic      clk16x;
    logic      arst_n;
    logic      req;
    tx_octet_t oct;
    logic      ack;
    logic      txd;
    logic      tx_en;
    logic      underrun;
    logic      busy;

    // host side and frame context
    logic [31:0] lfsr_q;
    logic [7:0]  frame_data [0:7];
    int          cur_len;
    string       cur_name;
    int          other_errors;
    int          f;
    int          v;

    // line decoder state
    int      en_cycles   = 0;
    int      burst_len   = 0;
    int      burst_count = 0;
    logic    first_half  = 1'b0;
    tx_sym_t dec_sym     = ONE;
    int      dec_idx     = 0;
    logic    dec_valid   = 1'b0;

    // compare state
    tx_sym_t exp_sym     = ONE;
    int      sym_checked = 0;
    int      sym_errors  = 0;

    int cycles = 0;

    fb_tx_top #(.PREAMBLE_OCTETS(PREAMBLE_OCTETS)) DUT
    (
        .clk16x   (clk16x),
        .arst_n   (arst_n),
        .req      (req),
        .oct      (oct),
        .ack      (ack),
        .txd      (txd),
        .tx_en    (tx_en),
        .underrun (underrun),
        .busy     (busy)
    );

    always #2 clk16x = ~clk16x;

    // ****************************************
    // random source and reference
    // ****************************************

    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic int random_bits(input int n);
        int   r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++)
        begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // expected symbol k of a frame of n octets
    function automatic tx_sym_t ref_symbol(input int n, input int k);
        int          pos;
        logic [15:0] crc;
        logic        fb;
        pos = k;
        if (pos < 8 * PREAMBLE_OCTETS)
        begin
            // 10101010 per preamble octet
            return pos[0] ? ZERO : ONE;
        end
        pos = pos - 8 * PREAMBLE_OCTETS;
        if (pos < 8)
        begin
            return tx_sym_t'(SD_SEQ[15 - 2 * pos -: 2]);
        end
        pos = pos - 8;
        if (pos < 8 * n)
        begin
            // msb first
            return frame_data[pos / 8][7 - pos % 8] ? ONE : ZERO;
        end
        pos = pos - 8 * n;
        if (pos < 16)
        begin
            crc = 16'hffff;
            for (int i = 0; i < n; i++)
            begin
                for (int j = 7; j >= 0; j--)
                begin
                    fb  = frame_data[i][j] ^ crc[15];
                    crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1dcf : 16'h0000);
                end
            end
            // complement goes out top bit first
            return crc[15 - pos] ? ZERO : ONE;
        end
        pos = pos - 16;
        if (pos < 8)
        begin
            return tx_sym_t'(ED_SEQ[15 - 2 * pos -: 2]);
        end
        // nothing is sent after the end delimiter
        return NMINUS;
    endfunction

    // ****************************************
    // line decoder and compare
    // ****************************************

    // cycle 0 is the first cycle with tx_en high
    always @(negedge clk16x)
    begin
        dec_valid = 1'b0;
        if (tx_en)
        begin
            if ((en_cycles % 16) == 4)
            begin
                first_half = txd;
            end
            else if ((en_cycles % 16) == 12)
            begin
                case ({first_half, txd})
                    2'b10:   dec_sym = ONE;
                    2'b01:   dec_sym = ZERO;
                    2'b11:   dec_sym = NPLUS;
                    default: dec_sym = NMINUS;
                endcase
                dec_idx   = en_cycles / 16;
                dec_valid = 1'b1;
            end
            en_cycles++;
        end
        else if (en_cycles != 0)
        begin
            // end of a burst
            burst_len = en_cycles;
            burst_count++;
            en_cycles = 0;
        end
    end

    always @(posedge clk16x)
    begin
        if (dec_valid)
        begin
            exp_sym = ref_symbol(cur_len, dec_idx);
            sym_checked++;
            assert (dec_sym == exp_sym)
            else
            begin
                sym_errors++;
                $display("ERROR %s symbol %0d: expected %s actual %s",
                         cur_name, dec_idx, exp_sym.name(), dec_sym.name());
            end
        end
    end

    always @(posedge clk16x)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ****************************************
    // host model and frame runs
    // ****************************************

    // four-phase handshake for one octet
    task automatic host_send(input logic [7:0] d, input logic last);
        @(negedge clk16x);
        oct.data = d;
        oct.last = last;
        req      = 1'b1;
        do
        begin
            @(negedge clk16x);
        end
        while (!ack);
        req = 1'b0;
        do
        begin
            @(negedge clk16x);
        end
        while (ack);
    endtask

    task automatic check_equal(input string what, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            other_errors++;
            $display("ERROR %s %s: expected %0d actual %0d", cur_name, what, expected, actual);
        end
    endtask

    // withhold sends only the first octet with last clear
    task automatic run_frame(input string name, input int n, input int delay_bits,
                             input bit withhold);
        int d;
        int r;
        int exp_syms;
        int start_bursts;
        int start_checked;
        cur_name = name;
        cur_len  = n;
        for (int i = 0; i < n; i++)
        begin
            r             = random_bits(8);
            frame_data[i] = r[7:0];
        end
        exp_syms      = withhold ? 8 * PREAMBLE_OCTETS + 16 : frame_symbols(n);
        start_bursts  = burst_count;
        start_checked = sym_checked;
        for (int i = 0; i < (withhold ? 1 : n); i++)
        begin
            d = random_bits(delay_bits);
            repeat (d) @(negedge clk16x);
            host_send(frame_data[i], (i == n - 1));
            if (i == 0)
            begin
                // frame start clears any old underrun
                check_equal("underrun at start", 0, int'(underrun));
                check_equal("busy at start", 1, int'(busy));
            end
        end
        while (burst_count == start_bursts)
        begin
            @(posedge clk16x);
        end
        @(negedge clk16x);
        check_equal("tx_en cycles", 16 * exp_syms, burst_len);
        check_equal("symbols decoded", exp_syms, sym_checked - start_checked);
        check_equal("underrun at end", withhold ? 1 : 0, int'(underrun));
        check_equal("busy after frame", 0, int'(busy));
        check_equal("ack after frame", 0, int'(ack));
    endtask

    initial
    begin
        clk16x       = 1'b0;
        arst_n       = 1'b0;
        req          = 1'b0;
        oct          = '0;
        lfsr_q       = 32'h25ae;
        cur_len      = 1;
        cur_name     = "reset";
        other_errors = 0;
        repeat (2) @(negedge clk16x);
        arst_n = 1'b1;
        repeat (4) @(negedge clk16x);
        run_frame("single", 1, 0, 1'b0);
        // host delays below 8 bit times
        for (f = 0; f < NUM_RANDOM; f++)
        begin
            v = random_bits(3);
            run_frame("random", v + 1, 7, 1'b0);
        end
        run_frame("underrun", 3, 0, 1'b1);
        run_frame("back_to_back_a", 2, 0, 1'b0);
        run_frame("back_to_back_b", 3, 0, 1'b0);
        $display("errors: %0d symbol, %0d other, %0d symbols checked",
                 sym_errors, other_errors, sym_checked);
        if ((sym_errors == 0) && (other_errors == 0))
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: files.f
src/fb_tx_pkg.sv
src/tx_serializer.sv
src/tfcs.sv
src/tx_delimiter_gen.sv
src/tx_manchester.sv
src/fb_tx_top.sv
dv/fb_tx_assertions.sv
dv/tb_fb_tx.sv

// File: Makefile
# verilator build and run for the fieldbus h1 transmit subsystem

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_fb_tx
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides the result, the simulator status alone does not
run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
